// ==== hdl/rv_consts.svh ====
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// ==========================================================================
// Datapath widths.
// ==========================================================================
`define XLEN            32
`define ADDR_WIDTH      32

// Data memory geometry and access wait.
`define MEM_DEPTH_LOG2  6       // 64 words.
`define MEM_WAIT        3       // Wait cycles per data access.

// ==========================================================================
// RV32I major opcodes.
// ==========================================================================
`define OP_R            7'b0110011
`define OP_I            7'b0010011
`define OP_LOAD         7'b0000011
`define OP_S            7'b0100011
`define OP_B            7'b1100011
`define OP_UPC          7'b0010111  // AUIPC.
`define OP_LUI          7'b0110111

// ALU control codes.
`define ALU_ADD         4'd0
`define ALU_SUB         4'd1
`define ALU_SLL         4'd2
`define ALU_SLT         4'd3
`define ALU_SLTU        4'd4
`define ALU_XOR         4'd5
`define ALU_SRL         4'd6
`define ALU_SRA         4'd7
`define ALU_OR          4'd8
`define ALU_AND         4'd9
`define ALU_PASSB       4'd10       // LUI.

`endif

// ==== hdl/rv_pkg.sv ====
`include "rv_consts.svh"

package rv_pkg;

	// ======================================================================
	// Datapath vectors.
	// ======================================================================
	typedef logic [`XLEN-1:0]       word_t;     // Data word.
	typedef logic [`ADDR_WIDTH-1:0] addr_t;     // Address or PC.

	// Decoded instruction fields.
	typedef logic [4:0] reg_idx_t;              // x0..x31.
	typedef logic [3:0] alu_ctrl_t;
	typedef logic [2:0] func3_t;
	typedef logic [6:0] opcode_t;

	// ======================================================================
	// Memory stage sequencing.
	// ======================================================================
	typedef enum logic [1:0] {
		MEM_IDLE = 2'd0,    // Accepting items from execute.
		MEM_WAIT = 2'd1,    // Timer running.
		MEM_DONE = 2'd2     // Access strobe.
	} mem_state_t;

endpackage

// ==== hdl/rv_alu.sv ====
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_alu (
	input  rv_pkg::word_t     i_op1,
	input  rv_pkg::word_t     i_op2,
	input  rv_pkg::alu_ctrl_t i_alu_ctrl,
	output rv_pkg::word_t     o_result
);
	import rv_pkg::*;

	logic [4:0] shamt;
	word_t      sra_res;

	assign shamt   = i_op2[4:0];    // Low five bits only.
	assign sra_res = word_t'($signed(i_op1) >>> shamt);

	always_comb begin
		case (i_alu_ctrl)
			`ALU_ADD:   o_result = i_op1 + i_op2;
			`ALU_SUB:   o_result = i_op1 - i_op2;
			`ALU_SLL:   o_result = i_op1 << shamt;
			`ALU_SLT:   o_result = word_t'($signed(i_op1) < $signed(i_op2));
			`ALU_SLTU:  o_result = word_t'(i_op1 < i_op2);
			`ALU_XOR:   o_result = i_op1 ^ i_op2;
			`ALU_SRL:   o_result = i_op1 >> shamt;
			`ALU_SRA:   o_result = sra_res;     // Sign fill.
			`ALU_OR:    o_result = i_op1 | i_op2;
			`ALU_AND:   o_result = i_op1 & i_op2;
			`ALU_PASSB: o_result = i_op2;       // Upper immediate.
			default:    o_result = '0;
		endcase
	end

endmodule

// ==== hdl/rv_execute.sv ====
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_execute (
	input  logic              clk,
	input  logic              rst_n,
	// Decode side.
	input  rv_pkg::word_t     i_rs1_data,
	input  rv_pkg::word_t     i_rs2_data,
	input  rv_pkg::word_t     i_imm_data,
	input  rv_pkg::addr_t     i_pc,
	input  rv_pkg::reg_idx_t  i_rd,
	input  rv_pkg::alu_ctrl_t i_alu_ctrl,
	input  rv_pkg::func3_t    i_func3,
	input  rv_pkg::opcode_t   i_opcode,
	input  logic              i_id_valid,
	output logic              o_stall,
	// Memory side.
	input  logic              i_stall,
	output rv_pkg::word_t     o_result,
	output rv_pkg::word_t     o_data_store,
	output rv_pkg::addr_t     o_pc,
	output rv_pkg::reg_idx_t  o_rd,
	output rv_pkg::func3_t    o_func3,
	output rv_pkg::opcode_t   o_opcode,
	output logic              o_ex_valid
);
	import rv_pkg::*;

	word_t op1, op2;
	word_t alu_result;
	word_t data_store;
	logic  load_en;

	// ======================================================================
	// Operand select and ALU.
	// ======================================================================
	assign op1 = (i_opcode == `OP_UPC) ? i_pc : i_rs1_data;    // AUIPC adds to PC.
	assign op2 = ((i_opcode == `OP_R) || (i_opcode == `OP_B)) ? i_rs2_data : i_imm_data;

	rv_alu u_alu (
		.i_op1      (op1),
		.i_op2      (op2),
		.i_alu_ctrl (i_alu_ctrl),
		.o_result   (alu_result)
	);

	assign data_store = (i_opcode == `OP_S) ? i_rs2_data : '0;

	// ======================================================================
	// EX/MEM pipeline register.
	// ======================================================================
	assign load_en = i_id_valid && !i_stall;
	assign o_stall = i_stall;   // Stage cannot accept.

	// Valid holds under stall so a waiting item reaches memory.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_ex_valid <= 1'b0;
		end else if (!i_stall) begin
			o_ex_valid <= i_id_valid;   // Fresh item or bubble.
		end
	end

	always_ff @(posedge clk) begin
		if (load_en) begin
			o_result     <= alu_result;
			o_data_store <= data_store;
			o_pc         <= i_pc;
			o_rd         <= i_rd;
			o_func3      <= i_func3;    // Width hint for later stages.
			o_opcode     <= i_opcode;
		end
	end

endmodule

// ==== hdl/rv_mem_fsm.sv ====
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_mem_fsm (
	input  logic                       clk,
	input  logic                       rst_n,
	// From execute.
	input  logic                       i_ex_valid,
	input  rv_pkg::word_t              i_result,
	input  rv_pkg::word_t              i_data_store,
	input  rv_pkg::reg_idx_t           i_rd,
	input  rv_pkg::opcode_t            i_opcode,
	output logic                       o_stall,
	// Timer.
	output logic                       o_timer_start,
	input  logic                       i_timer_done,
	// Data memory.
	output logic                       o_mem_we,
	output logic                       o_mem_re,
	output logic [`MEM_DEPTH_LOG2-1:0] o_mem_addr,
	output rv_pkg::word_t              o_mem_wdata,
	input  rv_pkg::word_t              i_mem_rdata,
	// Writeback.
	output logic                       o_wb_valid,
	output rv_pkg::reg_idx_t           o_wb_rd,
	output rv_pkg::word_t              o_wb_data
);
	import rv_pkg::*;

	mem_state_t state;
	logic       is_load, is_store, is_mem;
	logic       accept;
	logic       load_q;         // Pending access is a load.
	logic       wb_from_mem;    // Writeback data is the memory read.
	word_t      wb_data_q;
	reg_idx_t   rd_q;

	assign is_load  = (i_opcode == `OP_LOAD);
	assign is_store = (i_opcode == `OP_S);
	assign is_mem   = is_load || is_store;
	assign accept   = i_ex_valid && (state == MEM_IDLE);

	assign o_stall       = (state != MEM_IDLE);
	assign o_timer_start = accept && is_mem;
	assign o_mem_we      = (state == MEM_DONE) && !load_q;
	assign o_mem_re      = (state == MEM_DONE) && load_q;
	assign o_wb_data     = wb_from_mem ? i_mem_rdata : wb_data_q;  // Read lands late.

	// ======================================================================
	// Access sequencing and writeback strobe.
	// ======================================================================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state       <= MEM_IDLE;
			load_q      <= 1'b0;
			o_wb_valid  <= 1'b0;
			wb_from_mem <= 1'b0;
		end else begin
			o_wb_valid <= 1'b0;     // One-cycle strobe.
			case (state)
				MEM_IDLE: begin
					if (accept && is_mem) begin
						state  <= MEM_WAIT;
						load_q <= is_load;
					end else if (accept) begin
						// Branches and x0 never write back.
						o_wb_valid  <= (i_opcode != `OP_B) && (i_rd != '0);
						wb_from_mem <= 1'b0;
					end
				end
				MEM_WAIT: begin
					if (i_timer_done)
						state <= MEM_DONE;
				end
				MEM_DONE: begin
					state       <= MEM_IDLE;
					o_wb_valid  <= load_q && (rd_q != '0);
					wb_from_mem <= 1'b1;
				end
				default: state <= MEM_IDLE;
			endcase
		end
	end

	// Payload capture.
	always_ff @(posedge clk) begin
		if (accept && is_mem) begin
			o_mem_addr  <= i_result[`MEM_DEPTH_LOG2-1:0];   // Word index.
			o_mem_wdata <= i_data_store;
			rd_q        <= i_rd;
		end
		if (accept && !is_mem)
			wb_data_q <= i_result;
		if (state == MEM_DONE)
			o_wb_rd <= rd_q;
		else if (accept && !is_mem)
			o_wb_rd <= i_rd;
	end

endmodule

// ==== hdl/rv_wait_timer.sv ====
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_wait_timer (
	input  logic clk,
	input  logic rst_n,
	input  logic i_start,
	output logic o_done
);
	localparam int CNT_W = $clog2(`MEM_WAIT + 1);

	logic [CNT_W-1:0] cnt;
	logic             busy;

	assign o_done = busy && (cnt == '0);    // Last wait cycle.

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt  <= '0;
			busy <= 1'b0;
		end else if (i_start) begin
			cnt  <= CNT_W'(`MEM_WAIT - 1);  // Restart wins.
			busy <= 1'b1;
		end else if (o_done) begin
			busy <= 1'b0;
		end else if (busy) begin
			cnt <= cnt - 1'b1;
		end
	end

endmodule

// ==== hdl/rv_data_mem.sv ====
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_data_mem (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       i_we,
	input  logic                       i_re,
	input  logic [`MEM_DEPTH_LOG2-1:0] i_addr,
	input  rv_pkg::word_t              i_wdata,
	output rv_pkg::word_t              o_rdata
);
	import rv_pkg::*;

	localparam int DEPTH = 1 << `MEM_DEPTH_LOG2;

	word_t mem [DEPTH];

	// Cleared storage, synchronous write, read on request.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < DEPTH; i++)
				mem[i] <= '0;
			o_rdata <= '0;
		end else begin
			if (i_we)
				mem[i_addr] <= i_wdata;
			if (i_re)
				o_rdata <= mem[i_addr];     // Valid next cycle.
		end
	end

endmodule

// ==== hdl/rv_ex_mem_top.sv ====
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_ex_mem_top (
	input  logic              clk,
	input  logic              rst_n,
	// Decoded instruction.
	input  rv_pkg::word_t     i_rs1_data,
	input  rv_pkg::word_t     i_rs2_data,
	input  rv_pkg::word_t     i_imm_data,
	input  rv_pkg::addr_t     i_pc,
	input  rv_pkg::reg_idx_t  i_rd,
	input  rv_pkg::alu_ctrl_t i_alu_ctrl,
	input  rv_pkg::func3_t    i_func3,
	input  rv_pkg::opcode_t   i_opcode,
	input  logic              i_id_valid,
	output logic              o_stall,
	// Writeback.
	output logic              o_wb_valid,
	output rv_pkg::reg_idx_t  o_wb_rd,
	output rv_pkg::word_t     o_wb_data
);
	import rv_pkg::*;

	// ======================================================================
	// Stage interconnect.
	// ======================================================================
	word_t                      ex_result, ex_data_store;
	reg_idx_t                   ex_rd;
	opcode_t                    ex_opcode;
	logic                       ex_valid;
	logic                       mem_stall;
	logic                       timer_start, timer_done;
	logic                       mem_we, mem_re;
	logic [`MEM_DEPTH_LOG2-1:0] mem_addr;
	word_t                      mem_wdata, mem_rdata;

	// PC and func3 ride along for byte lanes and branches later on.
	rv_execute u_ex (
		.clk          (clk),
		.rst_n        (rst_n),
		.i_rs1_data   (i_rs1_data),
		.i_rs2_data   (i_rs2_data),
		.i_imm_data   (i_imm_data),
		.i_pc         (i_pc),
		.i_rd         (i_rd),
		.i_alu_ctrl   (i_alu_ctrl),
		.i_func3      (i_func3),
		.i_opcode     (i_opcode),
		.i_id_valid   (i_id_valid),
		.o_stall      (o_stall),
		.i_stall      (mem_stall),
		.o_result     (ex_result),
		.o_data_store (ex_data_store),
		.o_pc         (),
		.o_rd         (ex_rd),
		.o_func3      (),
		.o_opcode     (ex_opcode),
		.o_ex_valid   (ex_valid)
	);

	rv_mem_fsm u_mem_fsm (
		.clk           (clk),
		.rst_n         (rst_n),
		.i_ex_valid    (ex_valid),
		.i_result      (ex_result),
		.i_data_store  (ex_data_store),
		.i_rd          (ex_rd),
		.i_opcode      (ex_opcode),
		.o_stall       (mem_stall),
		.o_timer_start (timer_start),
		.i_timer_done  (timer_done),
		.o_mem_we      (mem_we),
		.o_mem_re      (mem_re),
		.o_mem_addr    (mem_addr),
		.o_mem_wdata   (mem_wdata),
		.i_mem_rdata   (mem_rdata),
		.o_wb_valid    (o_wb_valid),
		.o_wb_rd       (o_wb_rd),
		.o_wb_data     (o_wb_data)
	);

	rv_wait_timer u_timer (
		.clk     (clk),
		.rst_n   (rst_n),
		.i_start (timer_start),
		.o_done  (timer_done)
	);

	rv_data_mem u_dmem (
		.clk     (clk),
		.rst_n   (rst_n),
		.i_we    (mem_we),
		.i_re    (mem_re),
		.i_addr  (mem_addr),
		.i_wdata (mem_wdata),
		.o_rdata (mem_rdata)
	);

endmodule

// ==== dv/rv_ex_mem_props.sv ====
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_ex_mem_props (
	input logic               clk,
	input logic               rst_n,
	input logic               i_stall,
	input logic               i_wb_valid,
	input logic               i_mem_we,
	input logic               i_mem_re,
	input logic               i_timer_start,
	input logic               i_timer_done,
	input rv_pkg::mem_state_t i_state
);
	import rv_pkg::*;

	int fail_count;     // Failed assertions so far.

	initial fail_count = 0;

	// Quiet right after reset release.
	a_wb_after_reset: assert property (@(posedge clk)
		$rose(rst_n) |-> !i_wb_valid ##1 !i_wb_valid)
		else begin
			fail_count++;
			$error("Writeback strobe right after reset release");
		end

	// A data access strobe only ends a finished wait.
	a_strobe_after_wait: assert property (@(posedge clk) disable iff (!rst_n)
		(i_mem_we || i_mem_re) |-> $past(i_timer_done))
		else begin
			fail_count++;
			$error("Memory strobe without a finished access wait");
		end

	// Access strobe, then stall released the next cycle.
	a_stall_release: assert property (@(posedge clk) disable iff (!rst_n)
		i_timer_start |-> ##(`MEM_WAIT + 1) (i_state == MEM_DONE) ##1 $fell(i_stall))
		else begin
			fail_count++;
			$error("Stall not released right after the memory access");
		end

	// Wait length fixed by the header.
	a_timer_done: assert property (@(posedge clk) disable iff (!rst_n)
		i_timer_start |-> ##`MEM_WAIT i_timer_done)
		else begin
			fail_count++;
			$error("Timer done missing after the access wait");
		end

endmodule

bind rv_ex_mem_top rv_ex_mem_props u_props (
	.clk           (clk),
	.rst_n         (rst_n),
	.i_stall       (o_stall),
	.i_wb_valid    (o_wb_valid),
	.i_mem_we      (mem_we),
	.i_mem_re      (mem_re),
	.i_timer_start (timer_start),
	.i_timer_done  (timer_done),
	.i_state       (u_mem_fsm.state)
);

// ==== dv/rv_checker.sv ====
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_checker (
	input  logic             clk,
	input  logic             i_id_valid,
	input  logic             i_stall,
	input  logic             i_wb_valid,
	input  rv_pkg::reg_idx_t i_wb_rd,
	input  rv_pkg::word_t    i_wb_data,
	output int               o_err_count,
	output int               o_pending
);
	import rv_pkg::*;

	typedef struct packed {
		logic     wb;       // Writeback expected.
		logic     alu_op;   // Neither load nor store.
		reg_idx_t rd;
		word_t    data;
	} exp_t;

	exp_t prog_q [$];       // Every line, program order.
	exp_t wb_q [$];         // Accepted, writeback owed.
	int   err_count  = 0;
	int   n_accepted = 0;
	logic alu_cand   = 1'b0;    // ALU op accepted last sample.
	logic wb_due     = 1'b0;    // Strobe required this sample.

	assign o_err_count = err_count;
	assign o_pending   = wb_q.size();

	// Expected results, read on its own from the stimulus file.
	initial begin
		int          fd;
		string       line;
		logic [31:0] f_op, f_alu, f_f3, f_rd, f_rs1, f_rs2, f_imm, f_pc, f_wb, f_exp;
		exp_t        e;
		fd = $fopen("dv/ex_stimulus.txt", "r");
		if (fd != 0) begin
			while ($fgets(line, fd) != 0) begin
				if ($sscanf(line, "%h %h %h %h %h %h %h %h %h %h", f_op, f_alu, f_f3,
						f_rd, f_rs1, f_rs2, f_imm, f_pc, f_wb, f_exp) == 10) begin
					e.wb     = f_wb[0];
					e.alu_op = (f_op[6:0] != `OP_LOAD) && (f_op[6:0] != `OP_S);
					e.rd     = f_rd[4:0];
					e.data   = f_exp;
					prog_q.push_back(e);
				end
			end
			$fclose(fd);
		end else begin
			err_count++;
			$display("Checker could not open the stimulus file");
		end
	end

	// ======================================================================
	// Mid-cycle sampling, all DUT outputs settled.
	// ======================================================================
	always @(negedge clk) begin
		exp_t e;
		// ALU op with memory idle must write back on this sample.
		if (wb_due && !i_wb_valid) begin
			err_count++;
			$display("Fail %0t: no writeback 2 cycles after an ALU op was accepted", $time);
		end
		wb_due   = alu_cand && !i_stall;    // Memory takes it at the coming edge.
		alu_cand = 1'b0;

		if (i_wb_valid) begin
			if (wb_q.size() == 0) begin
				err_count++;
				$display("Writeback to x%0d at %0t arrived with nothing expected",
					i_wb_rd, $time);
			end else begin
				e = wb_q.pop_front();   // In program order.
				if (i_wb_rd !== e.rd || i_wb_data !== e.data) begin
					err_count++;
					$display("Fail %0t: writeback x%0d = %h, expected x%0d = %h",
						$time, i_wb_rd, i_wb_data, e.rd, e.data);
				end
			end
		end

		// Accept at the coming edge.
		if (i_id_valid && !i_stall) begin
			if (n_accepted >= prog_q.size()) begin
				err_count++;
				$display("The DUT accepted more instructions than the stimulus holds");
			end else begin
				e = prog_q[n_accepted];
				n_accepted++;
				if (e.wb)
					wb_q.push_back(e);
				alu_cand = e.wb && e.alu_op;
			end
		end
	end

endmodule

// ==== dv/tb_top.sv ====
`timescale 1ns/1ps
`include "rv_consts.svh"

module tb_top;
	import rv_pkg::*;

	// One decoded instruction as the decode stage would present it.
	typedef struct packed {
		opcode_t   opcode;
		alu_ctrl_t alu_ctrl;
		func3_t    func3;
		reg_idx_t  rd;
		word_t     rs1;
		word_t     rs2;
		word_t     imm;
		addr_t     pc;
	} instr_t;

	logic      clk;
	logic      rst_n;
	word_t     rs1_data, rs2_data, imm_data;
	addr_t     pc;
	reg_idx_t  rd;
	alu_ctrl_t alu_ctrl;
	func3_t    func3;
	opcode_t   opcode;
	logic      id_valid;
	logic      stall;
	logic      wb_valid;
	reg_idx_t  wb_rd;
	word_t     wb_data;
	int        chk_errors;
	int        chk_pending;     // Expected writebacks still owed.

	instr_t      prog_q [$];    // Program in file order.
	int unsigned cycle_cnt;
	int unsigned cycle_limit;   // Zero until the program is known.
	logic        file_ok;

	rv_ex_mem_top i_dut (
		.clk        (clk),
		.rst_n      (rst_n),
		.i_rs1_data (rs1_data),
		.i_rs2_data (rs2_data),
		.i_imm_data (imm_data),
		.i_pc       (pc),
		.i_rd       (rd),
		.i_alu_ctrl (alu_ctrl),
		.i_func3    (func3),
		.i_opcode   (opcode),
		.i_id_valid (id_valid),
		.o_stall    (stall),
		.o_wb_valid (wb_valid),
		.o_wb_rd    (wb_rd),
		.o_wb_data  (wb_data)
	);

	rv_checker u_chk (
		.clk         (clk),
		.i_id_valid  (id_valid),
		.i_stall     (stall),
		.i_wb_valid  (wb_valid),
		.i_wb_rd     (wb_rd),
		.i_wb_data   (wb_data),
		.o_err_count (chk_errors),
		.o_pending   (chk_pending)
	);

	// ======================================================================
	// Clock and run limit.
	// ======================================================================
	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;     // 40 ns period.
	end

	initial begin
		cycle_cnt = 0;
		wait (cycle_limit != 0);
		while (cycle_cnt < cycle_limit) begin
			@(posedge clk);
			cycle_cnt++;
		end
		$display("Run timed out after %0d cycles before the program drained", cycle_cnt);
		$display("Simulation finished: FAIL");
		$finish;
	end

	// Columns: opcode alu func3 rd rs1 rs2 imm pc wb expected.
	task automatic read_program(output logic ok);
		int          fd;
		string       line;
		logic [31:0] f_op, f_alu, f_f3, f_rd, f_rs1, f_rs2, f_imm, f_pc, f_wb, f_exp;
		instr_t      s;
		ok = 1'b0;
		fd = $fopen("dv/ex_stimulus.txt", "r");
		if (fd == 0) begin
			$display("Cannot open dv/ex_stimulus.txt for reading");
			return;
		end
		while ($fgets(line, fd) != 0) begin
			// Comment and blank lines do not scan.
			if ($sscanf(line, "%h %h %h %h %h %h %h %h %h %h", f_op, f_alu, f_f3, f_rd,
					f_rs1, f_rs2, f_imm, f_pc, f_wb, f_exp) == 10) begin
				s.opcode   = f_op[6:0];
				s.alu_ctrl = f_alu[3:0];
				s.func3    = f_f3[2:0];
				s.rd       = f_rd[4:0];
				s.rs1      = f_rs1;
				s.rs2      = f_rs2;
				s.imm      = f_imm;
				s.pc       = f_pc;
				prog_q.push_back(s);
			end
		end
		$fclose(fd);
		ok = (prog_q.size() != 0);
	endtask

	// Present one instruction and hold it until the stage takes it.
	task automatic drive_instr(input instr_t s);
		logic taken;
		rs1_data = s.rs1;
		rs2_data = s.rs2;
		imm_data = s.imm;
		pc       = s.pc;
		rd       = s.rd;
		alu_ctrl = s.alu_ctrl;
		func3    = s.func3;
		opcode   = s.opcode;
		id_valid = 1'b1;
		taken    = 1'b0;
		while (!taken) begin
			@(negedge clk);
			taken = !stall;     // Stall level at the coming edge.
			@(posedge clk);
			#1;
		end
		id_valid = 1'b0;
	endtask

	task automatic wait_drain();
		int unsigned n;
		n = 0;
		@(posedge clk);     // Last item still in execute.
		#1;
		while ((chk_pending != 0 || stall) && n < 4 * (`MEM_WAIT + 6)) begin
			@(posedge clk);
			#1;
			n++;
		end
		repeat (4) @(posedge clk);  // Room for a stray writeback.
	endtask

	task automatic report_and_finish();
		int asserts;
		asserts = i_dut.u_props.fail_count;
		$display("Checker errors: %0d, assertion failures: %0d, missing writebacks: %0d",
			chk_errors, asserts, chk_pending);
		if (file_ok && chk_errors == 0 && chk_pending == 0 && asserts == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	endtask

	// ======================================================================
	// Main sequence.
	// ======================================================================
	initial begin
		int unsigned idle;
		rst_n       = 1'b0;
		id_valid    = 1'b0;
		rs1_data    = '0;
		rs2_data    = '0;
		imm_data    = '0;
		pc          = '0;
		rd          = '0;
		alu_ctrl    = '0;
		func3       = '0;
		opcode      = '0;
		cycle_limit = 0;
		void'($urandom(32'ha816));
		read_program(file_ok);
		if (file_ok) begin
			cycle_limit = prog_q.size() * (`MEM_WAIT + 6) + 100;
			repeat (16) @(posedge clk);
			#1 rst_n = 1'b1;
			foreach (prog_q[i]) begin
				idle = $urandom % 3;    // 0 to 2 bubbles.
				repeat (idle) begin
					@(posedge clk);
					#1;
				end
				drive_instr(prog_q[i]);
			end
			wait_drain();
		end
		report_and_finish();
	end

endmodule

// ==== dv/ex_stimulus.txt ====
# opcode alu func3 rd rs1 rs2 imm pc wb expected  (all hex, one instruction per line)
# wb is 1 when a writeback of the expected word to rd must follow
33 0 0 01 00000005 00000007 000007ff 00000000 1 0000000c
33 1 0 02 00000003 00000005 000007ff 00000004 1 fffffffe
13 2 1 03 00000001 55555555 00000024 00000008 1 00000010
33 3 2 04 ffffffff 00000001 000007ff 0000000c 1 00000001
33 4 3 05 ffffffff 00000001 000007ff 00000010 1 00000000
13 5 4 06 f0f0f0f0 55555555 0ff00ff0 00000014 1 ff00ff00
33 6 5 07 80000000 00000004 000007ff 00000018 1 08000000
33 7 5 08 80000000 00000004 000007ff 0000001c 1 f8000000
13 8 6 09 12340000 55555555 00005678 00000020 1 12345678
33 9 7 0a ffff00ff 0f0f0f0f 000007ff 00000024 1 0f0f000f
37 a 0 0b deadbeef 55555555 abcde000 00000028 1 abcde000
17 0 0 0c 11111111 55555555 00001000 00000400 1 00001400
63 1 0 0d 00000005 00000005 00000040 00000404 0 00000000
33 0 0 00 00000001 00000002 000007ff 00000408 0 00000000
23 0 2 00 00000010 cafef00d 00000004 0000040c 0 00000000
03 0 2 0e 00000014 55555555 00000000 00000410 1 cafef00d
13 0 0 0f 00000001 55555555 00000002 00000414 1 00000003
03 0 2 10 00000020 55555555 00000001 00000418 1 00000000
23 0 2 00 00000000 0badf00d 00000008 0000041c 0 00000000
23 0 2 00 00000000 600dcafe 00000030 00000420 0 00000000
03 0 2 11 00000008 55555555 00000000 00000424 1 0badf00d
03 0 2 00 00000028 55555555 00000008 00000428 0 00000000
03 0 2 12 00000100 55555555 00000030 0000042c 1 600dcafe
33 1 0 13 00000010 00000001 000007ff 00000430 1 0000000f

// ==== all.f ====
+incdir+hdl
hdl/rv_pkg.sv
hdl/rv_alu.sv
hdl/rv_execute.sv
hdl/rv_mem_fsm.sv
hdl/rv_wait_timer.sv
hdl/rv_data_mem.sv
hdl/rv_ex_mem_top.sv
dv/rv_ex_mem_props.sv
dv/rv_checker.sv
dv/tb_top.sv

// ==== Makefile ====
SIM := obj_dir/Vtb_top

$(SIM): all.f $(wildcard hdl/*.sv hdl/*.svh dv/*.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f all.f

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qxF "Simulation finished: PASS"

clean:
	rm -rf obj_dir

.PHONY: run clean
